// File: rtl/drive_macros.svh
`ifndef DRIVE_MACROS_SVH
`define DRIVE_MACROS_SVH

// Clocks per bus bit
`define DRV_BIT_DIVIDER    8

// Clocks between two command frames
`define DRV_CMD_PERIOD     2000

// Clocks without an accepted status frame before the link reports an error
`define DRV_STATUS_TIMEOUT 6000

`define DRV_STATUS_ID      11'h01E
`define DRV_CMD_ID         11'h00D
`define DRV_STATUS_BYTES   8
`define DRV_CMD_BYTES      4

`endif

// File: rtl/drive_pkg.sv
package drive_pkg;

    // Base format frame as seen by the link, first data byte on the wire in data[63:56]
    typedef struct packed {
        logic [10:0] id;
        logic [3:0]  dlc;
        logic [63:0] data;
    } can_frame_t;

    // Status payload in wire order
    typedef struct packed {
        logic [0:3][7:0] position;   // Least significant byte first
        logic [0:1][7:0] power;      // Least significant byte first
        logic [7:0]      temp;
        logic            traj;
        logic            mot;
        logic            enc;
        logic            ctrl;
        logic [3:0]      state;
    } status_fields_t;

    // Same 64 bits read byte by byte or field by field
    typedef union packed {
        logic [0:7][7:0] bytes;
        status_fields_t  fields;
    } status_payload_u;

    typedef struct packed {
        logic [31:0] position;
        logic [15:0] power;
        logic [7:0]  temp;
        logic [3:0]  state;
        logic        traj;
        logic        mot;
        logic        enc;
        logic        ctrl;
    } drive_status_t;

    // Command payload, byte 0 goes out first
    typedef logic [0:3][7:0] cmd_payload_t;

endpackage

// File: rtl/can_crc15.sv
`timescale 1ns/1ps

module can_crc15 (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,
    input  logic        shift,
    input  logic        bit_in,
    output logic [14:0] crc
);

    logic fb;

    assign fb = crc[14] ^ bit_in;

    // Polynomial x^15 + x^14 + x^10 + x^8 + x^7 + x^4 + x^3 + 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= {crc[13:0], 1'b0} ^ (fb ? 15'h4599 : 15'h0000);
        end
    end

endmodule

// File: rtl/can_frame_rx.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module can_frame_rx #(
    parameter int DATA_BYTES = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rx,
    output logic                  ack_n,
    output drive_pkg::can_frame_t frame,
    output logic                  valid
);

    localparam int DIV     = `DRV_BIT_DIVIDER;
    localparam int DW      = $clog2(DIV);
    localparam int MAX_CNT = 34 + DATA_BYTES * 8;   // SOF, header, data and CRC bits
    localparam int CW      = $clog2(MAX_CNT + 1);

    typedef enum logic [1:0] {S_IDLE, S_BODY, S_ACK, S_WAIT} state_t;

    state_t          state;
    logic            rx_s;
    logic            rx_d;
    logic [DW-1:0]   div_cnt;
    logic [CW-1:0]   real_cnt;
    logic [CW-1:0]   last_cnt;
    logic [2:0]      run_len;
    logic            last_bit;
    logic [3:0]      idle_cnt;
    logic [17:0]     hdr;
    logic [63:0]     data;
    logic [14:0]     crc;
    logic            fall;
    logic            sample;
    logic            bit_end;
    logic            real_bit;
    logic            sof;
    logic [3:0]      dlc_in;
    logic [3:0]      nbytes;

    assign fall    = rx_d & ~rx_s;
    assign sample  = (div_cnt == DW'(DIV / 2));
    assign bit_end = (div_cnt == DW'(DIV - 1));
    assign sof     = (state == S_IDLE) && fall;

    // A sampled bit that is neither a stuff bit nor the CRC delimiter
    assign real_bit = (state == S_BODY) && sample && (run_len != 3'd5) && (real_cnt != last_cnt);

    assign dlc_in = {hdr[2:0], rx_s};
    assign nbytes = (dlc_in > 4'(DATA_BYTES)) ? 4'(DATA_BYTES) : dlc_in;

    assign frame.id   = hdr[17:7];
    assign frame.dlc  = hdr[3:0];
    assign frame.data = data;

    can_crc15 u_crc (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (sof),
        .shift  (real_bit),
        .bit_in (rx_s),
        .crc    (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_s    <= 1'b1;
            rx_d    <= 1'b1;
            div_cnt <= '0;
        end else begin
            rx_s <= rx;
            rx_d <= rx_s;
            if (sof || (state == S_BODY && fall)) begin
                div_cnt <= DW'(1);   // Hard sync on SOF, resync on later edges
            end else begin
                div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            valid    <= 1'b0;
            ack_n    <= 1'b1;
            real_cnt <= '0;
            last_cnt <= CW'(MAX_CNT);
            run_len  <= '0;
            last_bit <= 1'b0;
            idle_cnt <= '0;
        end else begin
            valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (fall) begin
                        state    <= S_BODY;
                        real_cnt <= '0;
                        last_cnt <= CW'(MAX_CNT);
                        run_len  <= '0;
                        last_bit <= 1'b0;
                    end
                end
                S_BODY: begin
                    if (sample) begin
                        if (real_cnt == '0 && rx_s) begin
                            state <= S_IDLE;   // Glitch, SOF did not hold
                        end else if (run_len == 3'd5) begin
                            if (rx_s == last_bit) begin
                                state    <= S_WAIT;
                                idle_cnt <= '0;
                            end
                            run_len  <= 3'd1;
                            last_bit <= rx_s;
                        end else if (real_cnt == last_cnt) begin
                            // CRC delimiter, the register is zero after a correct CRC
                            if (rx_s && crc == 15'd0) begin
                                valid <= 1'b1;
                                state <= S_ACK;
                            end else begin
                                state    <= S_WAIT;
                                idle_cnt <= '0;
                            end
                        end else begin
                            run_len  <= (rx_s == last_bit) ? run_len + 3'd1 : 3'd1;
                            last_bit <= rx_s;
                            real_cnt <= real_cnt + 1'b1;
                            if (real_cnt == CW'(18)) begin
                                last_cnt <= CW'(34 + 8 * int'(nbytes));
                            end
                        end
                    end
                end
                S_ACK: begin
                    if (bit_end) begin
                        ack_n <= ~ack_n;   // Low for the whole ACK slot
                        if (!ack_n) begin
                            state    <= S_WAIT;
                            idle_cnt <= 4'd4;
                        end
                    end
                end
                S_WAIT: begin
                    // Eleven recessive bits end the wait
                    if (sample) begin
                        if (!rx_s) begin
                            idle_cnt <= '0;
                        end else if (idle_cnt == 4'd10) begin
                            state <= S_IDLE;
                        end else begin
                            idle_cnt <= idle_cnt + 4'd1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sof) begin
            data <= '0;
        end else if (real_bit) begin
            if (real_cnt < CW'(19)) begin
                hdr <= {hdr[16:0], rx_s};   // SOF falls off the top
            end else if (real_cnt < last_cnt - CW'(15)) begin
                data <= {data[62:0], rx_s};
            end
        end
    end

endmodule

// File: rtl/can_frame_tx.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module can_frame_tx #(
    parameter int DATA_BYTES = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [10:0]             id,
    input  logic [DATA_BYTES*8-1:0] tx_data,
    input  logic                    start,
    output logic                    busy,
    output logic                    tx
);

    localparam int DIV       = `DRV_BIT_DIVIDER;
    localparam int DW        = $clog2(DIV);
    localparam int P         = 18 + DATA_BYTES * 8;   // Bits between SOF and CRC
    localparam int NREAL     = P + 15;
    localparam int CW        = $clog2(NREAL + 1);
    localparam int TAIL_BITS = 10;

    typedef enum logic [1:0] {S_IDLE, S_BODY, S_TAIL} state_t;

    state_t        state;
    logic [DW-1:0] div_cnt;
    logic [CW-1:0] real_cnt;
    logic [2:0]    run_len;
    logic [3:0]    tail_cnt;
    logic [P-1:0]  sr;
    logic [14:0]   crc;
    logic          load;
    logic          bit_end;
    logic          next_bit;
    logic          crc_shift;

    assign load    = (state == S_IDLE) && start;
    assign bit_end = (div_cnt == DW'(DIV - 1));

    // Header and data from the shift register, then the CRC MSB first
    assign next_bit  = (real_cnt < CW'(P)) ? sr[P-1] : crc[4'(P + 14 - int'(real_cnt))];
    assign crc_shift = (state == S_BODY) && bit_end && (run_len != 3'd5) && (real_cnt < CW'(P));

    can_crc15 u_crc (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (load),
        .shift  (crc_shift),
        .bit_in (next_bit),
        .crc    (crc)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            busy     <= 1'b0;
            tx       <= 1'b1;
            div_cnt  <= '0;
            real_cnt <= '0;
            run_len  <= '0;
            tail_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state    <= S_BODY;
                        busy     <= 1'b1;
                        tx       <= 1'b0;   // SOF
                        div_cnt  <= '0;
                        real_cnt <= '0;
                        run_len  <= 3'd1;
                    end
                end
                S_BODY: begin
                    div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
                    if (bit_end) begin
                        if (run_len == 3'd5) begin
                            tx      <= ~tx;   // Stuff bit
                            run_len <= 3'd1;
                        end else if (real_cnt == CW'(NREAL)) begin
                            state    <= S_TAIL;
                            tx       <= 1'b1;
                            tail_cnt <= '0;
                        end else begin
                            tx       <= next_bit;
                            run_len  <= (next_bit == tx) ? run_len + 3'd1 : 3'd1;
                            real_cnt <= real_cnt + 1'b1;
                        end
                    end
                end
                S_TAIL: begin
                    // CRC delimiter, ACK slot left recessive, ACK delimiter and EOF
                    div_cnt <= bit_end ? '0 : div_cnt + 1'b1;
                    if (bit_end) begin
                        tail_cnt <= tail_cnt + 4'd1;
                        if (tail_cnt == 4'(TAIL_BITS - 1)) begin
                            state <= S_IDLE;
                            busy  <= 1'b0;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // RTR, IDE and r0 are all dominant in a base data frame
    always_ff @(posedge clk) begin
        if (load) begin
            sr <= {id, 3'b000, 4'(DATA_BYTES), tx_data};
        end else if (crc_shift) begin
            sr <= {sr[P-2:0], 1'b0};
        end
    end

endmodule

// File: rtl/drive_link.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module drive_link (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sync,
    input  logic                     enable,
    input  logic [31:0]              velocity,
    input  logic                     rx,
    output logic                     tx,
    output drive_pkg::drive_status_t status,
    output logic                     error
);

    localparam int CMD_W = $clog2(`DRV_CMD_PERIOD + 1);
    localparam int WD_W  = $clog2(`DRV_STATUS_TIMEOUT + 1);

    logic                       rx_ack_n;
    logic                       tx_line;
    drive_pkg::can_frame_t      rx_frame;
    logic                       rx_valid;
    drive_pkg::status_payload_u payload;
    logic                       status_hit;
    logic [WD_W-1:0]            wd_cnt;
    logic [CMD_W-1:0]           cmd_cnt;
    logic                       cmd_event;
    logic                       tx_start;
    logic                       tx_busy;
    drive_pkg::cmd_payload_t    cmd_next;
    drive_pkg::cmd_payload_t    cmd_data;

    assign tx = tx_line & rx_ack_n;   // Wired-AND of the two open-drain drivers

    assign cmd_event = (cmd_cnt == '0) || sync;

    always_comb begin
        for (int i = 0; i < `DRV_CMD_BYTES; i++) begin
            cmd_next[i] = enable ? velocity[8*i +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_cnt  <= CMD_W'(`DRV_CMD_PERIOD);
            tx_start <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (cmd_event) begin
                cmd_cnt <= CMD_W'(`DRV_CMD_PERIOD);
                // No retry when the transmitter is still sending the last frame
                tx_start <= !tx_busy && !tx_start;
            end else begin
                cmd_cnt <= cmd_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_event) begin
            cmd_data <= cmd_next;
        end
    end

    assign payload    = rx_frame.data;
    assign status_hit = rx_valid && (rx_frame.id == `DRV_STATUS_ID) &&
                        (rx_frame.dlc == 4'(`DRV_STATUS_BYTES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status <= '0;
            error  <= 1'b0;
            wd_cnt <= WD_W'(`DRV_STATUS_TIMEOUT);
        end else if (status_hit) begin
            status.position <= {payload.bytes[3], payload.bytes[2],
                                payload.bytes[1], payload.bytes[0]};
            status.power    <= {payload.bytes[5], payload.bytes[4]};
            status.temp     <= payload.fields.temp;
            status.state    <= payload.fields.state;
            status.traj     <= payload.fields.traj;
            status.mot      <= payload.fields.mot;
            status.enc      <= payload.fields.enc;
            status.ctrl     <= payload.fields.ctrl;
            error  <= payload.fields.mot | payload.fields.enc | payload.fields.ctrl;
            wd_cnt <= WD_W'(`DRV_STATUS_TIMEOUT);
        end else if (wd_cnt == '0) begin
            error        <= 1'b1;   // Drive went silent
            status.state <= '0;
        end else begin
            wd_cnt <= wd_cnt - 1'b1;
        end
    end

    can_frame_rx #(
        .DATA_BYTES (`DRV_STATUS_BYTES)
    ) u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .ack_n (rx_ack_n),
        .frame (rx_frame),
        .valid (rx_valid)
    );

    can_frame_tx #(
        .DATA_BYTES (`DRV_CMD_BYTES)
    ) u_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .id      (`DRV_CMD_ID),
        .tx_data (cmd_data),
        .start   (tx_start),
        .busy    (tx_busy),
        .tx      (tx_line)
    );

endmodule

// File: rtl/drive_node_top.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module drive_node_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     sync,
    input  logic                     enable,
    input  logic [31:0]              velocity,
    input  logic                     rx,
    output logic                     tx,
    output drive_pkg::drive_status_t status,
    output logic                     error
);

    drive_link u_drive_link (
        .clk      (clk),
        .rst_n    (rst_n),
        .sync     (sync),
        .enable   (enable),
        .velocity (velocity),
        .rx       (rx),
        .tx       (tx),
        .status   (status),
        .error    (error)
    );

endmodule

// File: sim/drive_node_checker.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module drive_node_checker (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic                                      start,
    input logic                                      busy,
    input logic                                      valid,
    input logic                                      error,
    input logic                                      tx_line,
    input logic [$clog2(`DRV_STATUS_TIMEOUT + 1)-1:0] wd_cnt
);

    // A new frame only ever starts from an idle transmitter
    start_from_idle: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(start) |-> !busy
    ) else $error("transmitter start rose while busy was high");

    valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) valid |=> !valid
    ) else $error("receiver valid was high in two cycles in a row");

    // The first zero cycle may still accept a frame, from the second on error must hold
    silent_error: assert property (
        @(posedge clk) disable iff (!rst_n) (wd_cnt == '0) ##1 (wd_cnt == '0) |-> error
    ) else $error("watchdog at zero but error is low");

    idle_recessive: assert property (
        @(posedge clk) disable iff (!rst_n) !busy |-> tx_line
    ) else $error("transmitter drove the bus while not busy");

endmodule

// File: sim/tb_drive_node.sv
`timescale 1ns/1ps
`include "drive_macros.svh"

module tb_drive_node;

    localparam int DIV = `DRV_BIT_DIVIDER;
    localparam int PERIOD = `DRV_CMD_PERIOD;

    logic clk;
    logic rst_n;
    logic sync;
    logic enable;
    logic [31:0] velocity;
    logic rx;
    logic tx;
    logic tb_drv;
    logic error;
    drive_pkg::drive_status_t status;
    drive_pkg::drive_status_t snap;

    int errors;
    int test_errs;
    int tests;
    int waited;
    bit acked;
    logic [31:0] rng_state;
    logic [7:0] tx_bytes [8];
    logic [7:0] rx_bytes [8];
    logic [10:0] rx_id;
    logic [3:0] rx_dlc;
    bit rx_ok;
    int rx_wait;
    int rd_run;
    logic rd_last;
    bit rd_stuff_err;
    logic [14:0] rd_crc;
    string fail_reason;
    event abort_ev;

    assign rx = tx & tb_drv;   // Wired-AND of the DUT and the bus model

    drive_node_top u_drive_node_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .sync     (sync),
        .enable   (enable),
        .velocity (velocity),
        .rx       (rx),
        .tx       (tx),
        .status   (status),
        .error    (error)
    );

    bind drive_link drive_node_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tx_start),
        .busy    (tx_busy),
        .valid   (rx_valid),
        .error   (error),
        .tx_line (tx_line),
        .wd_cnt  (wd_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        @(abort_ev);
        $display("%s", fail_reason);
        $display("Regression failed");
        $finish;
    end

    // Hands the run over to the abort process and parks this one
    task automatic abort(input string msg);
        fail_reason = msg;
        -> abort_ev;
        forever @(negedge clk);
    endtask

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [14:0] crc_step(input logic [14:0] c, input logic b);
        logic fb;
        fb = c[14] ^ b;
        return {c[13:0], 1'b0} ^ (fb ? 15'h4599 : 15'h0000);
    endfunction

    // Number built from payload bytes that travel least significant first
    function automatic logic [31:0] le_value(input int first, input int count);
        logic [31:0] v;
        v = '0;
        for (int i = first + count - 1; i >= first; i--) v = {v[23:0], tx_bytes[i]};
        return v;
    endfunction

    task automatic check(input bit cond, input string msg);
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
            test_errs++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %s", name, (test_errs == 0) ? "ok" : "FAILED");
        test_errs = 0;
    endtask

    task automatic drive_bit(input logic b);
        tb_drv = b;
        repeat (DIV) @(negedge clk);
    endtask

    task automatic send_frame(input logic [10:0] id, input logic [3:0] dlc,
                              input bit bad_crc, output bit ack_seen);
        logic bits[$];
        logic [14:0] c;
        logic last;
        int run;
        int n;
        c = '0;
        n = (dlc > 4'd8) ? 8 : int'(dlc);
        bits.push_back(1'b0);
        for (int i = 10; i >= 0; i--) bits.push_back(id[i]);
        repeat (3) bits.push_back(1'b0);   // RTR, IDE, r0
        for (int i = 3; i >= 0; i--) bits.push_back(dlc[i]);
        for (int k = 0; k < n; k++) begin
            for (int i = 7; i >= 0; i--) bits.push_back(tx_bytes[k][i]);
        end
        foreach (bits[i]) c = crc_step(c, bits[i]);
        if (bad_crc) c[0] = ~c[0];
        for (int i = 14; i >= 0; i--) bits.push_back(c[i]);
        run = 0;
        last = 1'b1;
        foreach (bits[i]) begin
            drive_bit(bits[i]);
            if (run > 0 && bits[i] == last) begin
                run++;
            end else begin
                run = 1;
                last = bits[i];
            end
            if (run == 5) begin
                drive_bit(~last);   // Stuff bit
                last = ~last;
                run = 1;
            end
        end
        drive_bit(1'b1);
        tb_drv = 1'b1;
        repeat (DIV / 2) @(negedge clk);
        ack_seen = !rx;
        repeat (DIV / 2) @(negedge clk);
        repeat (8) drive_bit(1'b1);   // ACK delimiter and EOF
    endtask

    task automatic read_raw(output logic b);
        repeat (DIV) @(negedge clk);
        b = rx;
    endtask

    task automatic read_bit(output logic b);
        logic r;
        if (rd_run == 5) begin
            read_raw(r);
            if (r == rd_last) rd_stuff_err = 1'b1;
            rd_last = r;
            rd_run = 1;
        end
        read_raw(b);
        if (b == rd_last) begin
            rd_run++;
        end else begin
            rd_run = 1;
            rd_last = b;
        end
    endtask

    task automatic read_field(input int n, input bit crc_on, output logic [14:0] v);
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            read_bit(b);
            v = {v[13:0], b};
            if (crc_on) rd_crc = crc_step(rd_crc, b);
        end
    endtask

    task automatic read_frame(input int limit);
        logic [14:0] v;
        logic d;
        int n;
        rx_wait = 0;
        while (rx !== 1'b0) begin
            @(negedge clk);
            rx_wait++;
            if (rx_wait > limit) abort("No frame appeared on the bus in time");
        end
        repeat (DIV / 2 - 1) @(negedge clk);   // Middle of SOF
        rx_ok = (rx == 1'b0);
        rd_run = 1;
        rd_last = 1'b0;
        rd_stuff_err = 1'b0;
        rd_crc = '0;
        read_field(11, 1'b1, v);
        rx_id = v[10:0];
        read_field(3, 1'b1, v);
        read_field(4, 1'b1, v);
        rx_dlc = v[3:0];
        n = (rx_dlc > 4'd8) ? 8 : int'(rx_dlc);
        for (int i = 0; i < 8; i++) rx_bytes[i] = '0;
        for (int i = 0; i < n; i++) begin
            read_field(8, 1'b1, v);
            rx_bytes[i] = v[7:0];
        end
        read_field(15, 1'b0, v);
        read_bit(d);   // CRC delimiter
        rx_ok = rx_ok && (v == rd_crc) && d && !rd_stuff_err;
    endtask

    task automatic wait_idle();
        int quiet;
        int count;
        quiet = 0;
        count = 0;
        while (quiet < 12 * DIV) begin
            @(negedge clk);
            count++;
            quiet = rx ? quiet + 1 : 0;
            if (count > 4 * PERIOD) abort("The bus never went idle");
        end
    endtask

    task automatic check_command();
        logic [31:0] word;
        word = enable ? velocity : 32'h0;
        check(rx_ok, "command frame has a bad CRC or stuffing");
        check(rx_id == `DRV_CMD_ID, $sformatf("command id %h", rx_id));
        check(rx_dlc == 4'(`DRV_CMD_BYTES), $sformatf("command dlc %0d", rx_dlc));
        for (int i = 0; i < `DRV_CMD_BYTES; i++) begin
            check(rx_bytes[i] == word[7:0],
                  $sformatf("command byte %0d is %h, expected %h", i, rx_bytes[i], word[7:0]));
            word = word >> 8;   // The next byte on the wire is the next more significant one
        end
    endtask

    task automatic check_status();
        check(status.position == le_value(0, 4), $sformatf("position %h", status.position));
        check(status.power == le_value(4, 2), $sformatf("power %h", status.power));
        check(status.temp == tx_bytes[6], $sformatf("temp %h", status.temp));
        check(status.state == tx_bytes[7][3:0], $sformatf("state %h", status.state));
        check({status.traj, status.mot, status.enc, status.ctrl} == tx_bytes[7][7:4],
              "status flags");
        check(error == (|tx_bytes[7][6:4]), "error does not follow mot, enc and ctrl");
    endtask

    task automatic fill_payload();
        for (int i = 0; i < 8; i++) tx_bytes[i] = 8'(next_rand());
    endtask

    // Takes the next command frame, then answers in the gap before the following one
    task automatic run_exchange(input logic [10:0] id, input logic [3:0] dlc,
                                input bit bad_crc, output bit ack_seen);
        wait_idle();
        read_frame(3 * PERIOD);
        check_command();
        wait_idle();
        send_frame(id, dlc, bad_crc, ack_seen);
    endtask

    initial begin
        rst_n = 1'b0;
        sync = 1'b0;
        enable = 1'b1;
        velocity = 32'h0;
        tb_drv = 1'b1;
        rng_state = 32'd35;
        errors = 0;
        tests = 0;
        test_errs = 0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int k = 0; k < 3; k++) begin
            velocity = next_rand();
            fill_payload();
            run_exchange(`DRV_STATUS_ID, 4'd8, 1'b0, acked);
            check(acked, "good status frame saw no ACK");
            check_status();
        end
        end_test("status decode");

        snap = status;
        fill_payload();
        run_exchange(11'h01F, 4'd8, 1'b0, acked);
        check(status == snap, "frame with another id changed the status");
        fill_payload();
        run_exchange(`DRV_STATUS_ID, 4'd8, 1'b0, acked);   // Keeps the watchdog fed
        check_status();
        snap = status;
        fill_payload();
        run_exchange(`DRV_STATUS_ID, 4'd4, 1'b0, acked);
        check(status == snap, "frame with dlc 4 changed the status");
        end_test("status filter");

        fill_payload();
        tx_bytes[7] = {4'h0, tx_bytes[7][3:0] | 4'h1};
        run_exchange(`DRV_STATUS_ID, 4'd8, 1'b0, acked);
        check(acked, "good status frame saw no ACK");
        check_status();
        snap = status;
        fill_payload();
        run_exchange(`DRV_STATUS_ID, 4'd8, 1'b1, acked);
        check(!acked, "frame with a bad CRC was acknowledged");
        check(status == snap, "frame with a bad CRC changed the status");
        end_test("crc and ack");

        waited = 0;
        while (!error) begin
            @(negedge clk);
            waited++;
            if (waited > `DRV_STATUS_TIMEOUT + PERIOD) abort("Watchdog error never rose");
        end
        check(waited > `DRV_STATUS_TIMEOUT / 2, $sformatf("error rose after %0d cycles", waited));
        check(status.state == 4'h0, "state not cleared on timeout");
        fill_payload();
        tx_bytes[7] = {4'h0, tx_bytes[7][3:0] | 4'h1};
        run_exchange(`DRV_STATUS_ID, 4'd8, 1'b0, acked);
        check(!error, "good frame did not clear the timeout error");
        check_status();
        end_test("watchdog");

        enable = 1'b0;
        velocity = next_rand();
        run_exchange(`DRV_STATUS_ID, 4'd8, 1'b0, acked);
        enable = 1'b1;
        velocity = next_rand();
        wait_idle();
        read_frame(3 * PERIOD);
        check_command();
        wait_idle();
        sync = 1'b1;
        @(negedge clk);
        sync = 1'b0;
        read_frame(3 * PERIOD);
        sync = 1'b1;   // Lands in the frame tail while the transmitter is still busy
        @(negedge clk);
        sync = 1'b0;
        check_command();
        check(rx_wait < PERIOD / 4, $sformatf("sync frame started after %0d cycles", rx_wait));
        end_test("command frames");

        $display("tests run: %0d, checks failed: %0d", tests, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+rtl
rtl/drive_pkg.sv
rtl/can_crc15.sv
rtl/can_frame_rx.sv
rtl/can_frame_tx.sv
rtl/drive_link.sv
rtl/drive_node_top.sv
sim/drive_node_checker.sv
sim/tb_drive_node.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_drive_node
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST)) rtl/drive_macros.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
